//--- Makefile
# Verilator build and run of the supervised synapse316 testbench.
VERILATOR  ?= verilator
TOP        ?= tb_supervised_synapse316
RTL_TOP    ?= supervised_synapse316
FILELIST   ?= supervised_synapse316.f
FLAGS      ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the simulation output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/program_rom.sv
`timescale 1ns/1ps

module program_rom import synapse_pkg::*; (
    input  logic                  sysclk,
    input  logic [ROM_ADDR_W-1:0] code_addr,
    output logic [WORD_W-1:0]     code_data,
    output logic                  code_ready
);

    logic [WORD_W-1:0]     rom [ROM_DEPTH];
    logic [ROM_ADDR_W-1:0] last_addr;

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    // Synchronous read, the word shows up one clock after its address.
    always_ff @(posedge sysclk) begin
        code_data <= rom[code_addr];
        last_addr <= code_addr;      // Address that code_data belongs to.
    end

    // A stable address means the registered word already matches it.
    assign code_ready = (code_addr == last_addr);

endmodule

//--- logic/reg_bank.sv
`timescale 1ns/1ps

module reg_bank import synapse_pkg::*; (
    input  logic                       sysclk,
    input  logic                       arst_n,
    input  logic                       clear,
    input  logic                       wr_en,
    input  logic [REG_IDX_W-1:0]       wr_idx,
    input  logic [WORD_W-1:0]          wr_data,
    input  logic [REG_IDX_W-1:0]       rd_a_idx,
    input  logic [REG_IDX_W-1:0]       rd_b_idx,
    output logic [WORD_W-1:0]          rd_a,
    output logic [WORD_W-1:0]          rd_b,
    output logic [NUM_REGS*WORD_W-1:0] r_flat,
    output logic [NUM_REGS-1:0]        r_load
);

    logic [WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            regs   <= '{default: '0};
            r_load <= '0;
        end else if (clear) begin
            regs   <= '{default: '0};                   // Supervisor restart wipes the file.
            r_load <= '0;
        end else begin
            if (wr_en) begin
                regs[wr_idx] <= wr_data;
            end
            // The strobe lines up with the cycle in which r_flat shows the new value.
            r_load <= wr_en ? (NUM_REGS'(1) << wr_idx) : '0;
        end
    end

    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            r_flat[i*WORD_W +: WORD_W] = regs[i];      // Register i sits at bits i*16 upward.
        end
    end

endmodule

//--- logic/supervised_synapse316.sv
`timescale 1ns/1ps

module supervised_synapse316 import synapse_pkg::*; (
    input  logic                             sysclk,
    input  logic                             arst_n,
    input  logic [NUM_EXT_INPUTS*WORD_W-1:0] data_in_flat,
    output logic [NUM_REGS*WORD_W-1:0]       r_flat,
    output logic [NUM_REGS-1:0]              r_load,
    output logic [LED_W-1:0]                 led
);

    // ROM bus between the code ROM and the supervisor.
    logic [ROM_ADDR_W-1:0] code_addr;
    logic [WORD_W-1:0]     code_data;
    logic                  code_ready;

    visor_link_if link ();

    program_rom u_rom (
        .sysclk     (sysclk),
        .code_addr  (code_addr),
        .code_data  (code_data),
        .code_ready (code_ready)
    );

    // The supervisor owns the core's restart and answers its mailbox.
    visor u_visor (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .code_addr  (code_addr),
        .code_data  (code_data),
        .code_ready (code_ready),
        .link       (link.supervisor),
        .led        (led)
    );

    synapse316 u_core (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .link         (link.target),
        .data_in_flat (data_in_flat),
        .r_flat       (r_flat),
        .r_load       (r_load)
    );

endmodule

//--- logic/synapse316.sv
`timescale 1ns/1ps

module synapse316 import synapse_pkg::*; (
    input  logic                             sysclk,
    input  logic                             arst_n,
    visor_link_if.target                     link,
    input  logic [NUM_EXT_INPUTS*WORD_W-1:0] data_in_flat,
    output logic [NUM_REGS*WORD_W-1:0]       r_flat,
    output logic [NUM_REGS-1:0]              r_load
);

    logic [1:0]            state;
    logic [ROM_ADDR_W-1:0] pc;
    logic [ROM_ADDR_W-1:0] next_pc;
    instr_t                ir;
    logic                  wr_en;
    logic [WORD_W-1:0]     wr_data;
    logic [WORD_W-1:0]     rd_a;
    logic [WORD_W-1:0]     rd_b;
    logic [WORD_W-1:0]     ext_word;

    // Sequencer. A restart from the supervisor acts like reset, but synchronously.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FETCH;
            pc    <= '0;
        end else if (link.tg_reset) begin
            state <= ST_FETCH;
            pc    <= '0;
        end else begin
            case (state)
                ST_FETCH: state <= ST_WAIT;
                ST_WAIT: begin
                    if (link.tg_code_ready) begin
                        state <= ST_EXEC;       // The ROM may take longer, so wait here.
                    end
                end
                ST_EXEC: begin
                    state <= ST_FETCH;
                    pc    <= next_pc;
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // Instruction register, loaded once the word for pc is ready.
    always_ff @(posedge sysclk) begin
        if (state == ST_WAIT && link.tg_code_ready) begin
            ir <= link.tg_code_in;
        end
    end

    // Input slot 15 is the mailbox reply, the others come from outside.
    always_comb begin
        if (ir.rform.src == REG_IDX_W'(NUM_EXT_INPUTS)) begin
            ext_word = link.from_visor;
        end else begin
            ext_word = data_in_flat[ir.rform.src*WORD_W +: WORD_W];
        end
    end

    // Decode and ALU.
    always_comb begin
        wr_en   = 1'b0;
        wr_data = rd_a;
        next_pc = pc + 1'b1;
        case (ir.rform.op)
            LDI: begin
                wr_en   = 1'b1;
                wr_data = WORD_W'(ir.iform.imm8);
            end
            MOV: begin
                wr_en   = 1'b1;
                wr_data = rd_b;
            end
            ADD: begin
                wr_en   = 1'b1;
                wr_data = rd_a + rd_b;
            end
            SUB: begin
                wr_en   = 1'b1;
                wr_data = rd_a - rd_b;
            end
            AND: begin
                wr_en   = 1'b1;
                wr_data = rd_a & rd_b;
            end
            XOR: begin
                wr_en   = 1'b1;
                wr_data = rd_a ^ rd_b;
            end
            IN: begin
                wr_en   = 1'b1;
                wr_data = ext_word;
            end
            JMP: next_pc = ir.iform.imm8;
            JNZ: begin
                if (rd_a != '0) begin
                    next_pc = ir.iform.imm8;    // Tests register dst, not src.
                end
            end
            default: ;                           // NOP and unused codes just advance.
        endcase
        if (state != ST_EXEC) begin
            wr_en = 1'b0;
        end
    end

    reg_bank u_reg_bank (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .clear    (link.tg_reset),
        .wr_en    (wr_en),
        .wr_idx   (ir.rform.dst),
        .wr_data  (wr_data),
        .rd_a_idx (ir.rform.dst),
        .rd_b_idx (ir.rform.src),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .r_flat   (r_flat),
        .r_load   (r_load)
    );

    assign link.tg_code_addr = pc;
    assign link.to_visor     = r_flat[MAILBOX_REG*WORD_W +: WORD_W];
    assign link.mail_strobe  = r_load[MAILBOX_REG];   // High while register 15 shows its new value.

endmodule

//--- logic/synapse_pkg.sv
package synapse_pkg;

    // Datapath and register file sizes.
    localparam int WORD_W         = 16;
    localparam int NUM_REGS       = 16;
    localparam int REG_IDX_W      = $clog2(NUM_REGS);
    localparam int NUM_EXT_INPUTS = 15;              // Slot 15 is answered by the supervisor.
    localparam int MAILBOX_REG    = 15;              // Writes to this register reach the supervisor.

    // Code ROM.
    localparam int    ROM_DEPTH  = 256;
    localparam int    ROM_ADDR_W = 8;
    localparam string ROM_FILE   = "program.hex";

    // Supervisor sizes.
    localparam int LED_W           = 6;
    localparam int WATCHDOG_CYCLES = 1024;           // Silent cycles tolerated before a restart.
    localparam int RESTART_CYCLES  = 4;              // Length of the core reset pulse.
    localparam int WDOG_CNT_W      = $clog2(WATCHDOG_CYCLES);
    localparam int PULSE_CNT_W     = $clog2(RESTART_CYCLES + 1);

    // Core sequencer states.
    localparam logic [1:0] ST_FETCH = 2'd0;          // Present the program counter to the ROM.
    localparam logic [1:0] ST_WAIT  = 2'd1;          // Hold until the ROM word is ready.
    localparam logic [1:0] ST_EXEC  = 2'd2;          // Execute and advance the program counter.

    typedef enum logic [3:0] {
        LDI = 4'h0,                                  // dst = zero-extended imm8.
        MOV = 4'h1,                                  // dst = src.
        ADD = 4'h2,
        SUB = 4'h3,
        AND = 4'h4,
        XOR = 4'h5,
        IN  = 4'h6,                                  // dst = data input slot src.
        JMP = 4'h7,                                  // pc = imm8.
        JNZ = 4'h8,                                  // pc = imm8 when dst is nonzero.
        NOP = 4'h9
    } opcode_t;

    // Every instruction word is read both ways and the opcode picks the valid view.
    typedef union packed {
        struct packed {
            opcode_t              op;
            logic [REG_IDX_W-1:0] dst;
            logic [REG_IDX_W-1:0] src;
            logic [3:0]           pad;
        } rform;
        struct packed {
            opcode_t              op;
            logic [REG_IDX_W-1:0] dst;
            logic [7:0]           imm8;
        } iform;
    } instr_t;

endpackage

//--- logic/visor.sv
`timescale 1ns/1ps

module visor import synapse_pkg::*; (
    input  logic                  sysclk,
    input  logic                  arst_n,
    output logic [ROM_ADDR_W-1:0] code_addr,
    input  logic [WORD_W-1:0]     code_data,
    input  logic                  code_ready,
    visor_link_if.supervisor      link,
    output logic [LED_W-1:0]      led
);

    logic [WORD_W-1:0]      reply_cnt;
    logic [WDOG_CNT_W-1:0]  silent_cnt;
    logic [PULSE_CNT_W-1:0] pulse_cnt;

    // Code fetches go straight through, no extra latency.
    assign code_addr          = link.tg_code_addr;
    assign link.tg_code_in    = code_data;
    assign link.tg_code_ready = code_ready;

    // Mailbox. Reply count and LEDs are kept across a core restart.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            reply_cnt <= '0;
            led       <= '0;
        end else if (link.mail_strobe) begin
            reply_cnt <= reply_cnt + 1'b1;
            led       <= link.to_visor[LED_W-1:0];
        end
    end

    assign link.from_visor = reply_cnt;

    // Watchdog. A silent mailbox for WATCHDOG_CYCLES cycles triggers a restart pulse.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            silent_cnt <= '0;
            pulse_cnt  <= '0;
        end else if (pulse_cnt != '0) begin
            pulse_cnt  <= pulse_cnt - 1'b1;
            silent_cnt <= '0;                        // Count again from the restart.
        end else if (link.mail_strobe) begin
            silent_cnt <= '0;
        end else if (silent_cnt == WDOG_CNT_W'(WATCHDOG_CYCLES - 1)) begin
            silent_cnt <= '0;
            pulse_cnt  <= PULSE_CNT_W'(RESTART_CYCLES);
        end else begin
            silent_cnt <= silent_cnt + 1'b1;
        end
    end

    assign link.tg_reset = (pulse_cnt != '0);

endmodule

//--- logic/visor_link_if.sv
`timescale 1ns/1ps

interface visor_link_if import synapse_pkg::*; ();

    logic                  tg_reset;       // Synchronous restart of the core.
    logic [WORD_W-1:0]     tg_code_in;     // ROM word forwarded to the core.
    logic                  tg_code_ready;
    logic [WORD_W-1:0]     from_visor;     // Mailbox reply seen on input slot 15.
    logic [ROM_ADDR_W-1:0] tg_code_addr;   // Core program counter.
    logic [WORD_W-1:0]     to_visor;       // Current value of register 15.
    logic                  mail_strobe;    // One cycle, register 15 holds a new value.

    modport supervisor (
        output tg_reset, tg_code_in, tg_code_ready, from_visor,
        input  tg_code_addr, to_visor, mail_strobe
    );

    modport target (
        input  tg_reset, tg_code_in, tg_code_ready, from_visor,
        output tg_code_addr, to_visor, mail_strobe
    );

endinterface

//--- program.hex
// One 16-bit word per line, address 0 upward.
// Fields: opcode[15:12] dst[11:8] src[7:4] unused[3:0], or opcode dst imm8[7:0].
6100 // 00 IN  r1, slot 0
6210 // 01 IN  r2, slot 1
2120 // 02 ADD r1, r2
6220 // 03 IN  r2, slot 2
3120 // 04 SUB r1, r2
63E0 // 05 IN  r3, slot 14
4320 // 06 AND r3, r2
5130 // 07 XOR r1, r3
64F0 // 08 IN  r4, slot 15 (reply count)
2140 // 09 ADD r1, r4
1F10 // 0A MOV r15, r1 (mailbox write)
65F0 // 0B IN  r5, slot 15 (reply count after the write)
6600 // 0C IN  r6, slot 0
0701 // 0D LDI r7, 1
2670 // 0E ADD r6, r7
8611 // 0F JNZ r6, 11
7010 // 10 JMP 10 (stall until the watchdog restarts the core)
9000 // 11 NOP
7000 // 12 JMP 00

//--- supervised_synapse316.f
+incdir+verification
logic/synapse_pkg.sv
logic/visor_link_if.sv
logic/program_rom.sv
logic/reg_bank.sv
logic/synapse316.sv
logic/visor.sv
logic/supervised_synapse316.sv
verification/tb_supervised_synapse316.sv

//--- verification/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Instruction-level reference for program.hex, advanced one register write at a time.
logic [WORD_W-1:0]     model_rom  [ROM_DEPTH];
logic [WORD_W-1:0]     model_regs [NUM_REGS];
logic [ROM_ADDR_W-1:0] model_pc;
logic [WORD_W-1:0]     model_replies;                 // Supervisor reply count.
logic [LED_W-1:0]      model_led;

// Core state only, as after a supervisor restart.
task automatic model_restart();
    for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    model_pc = '0;
endtask

task automatic model_load();
    $readmemh(ROM_FILE, model_rom);
    model_restart();
    model_replies = '0;
    model_led     = '0;
endtask

// Runs past jumps and NOPs up to the next instruction that writes a register.
task automatic model_next_write(input  logic [NUM_EXT_INPUTS*WORD_W-1:0] ext,
                                output bit                               found,
                                output logic [REG_IDX_W-1:0]             idx,
                                output logic [WORD_W-1:0]                val);
    logic [WORD_W-1:0]    word;
    logic [REG_IDX_W-1:0] dst;
    logic [REG_IDX_W-1:0] src;
    logic [WORD_W-1:0]    a;
    logic [WORD_W-1:0]    b;
    found = 1'b0;
    idx   = '0;
    val   = '0;
    dst   = '0;
    for (int n = 0; n < 64 && !found; n++) begin
        word     = model_rom[model_pc];
        dst      = word[11:8];
        src      = word[7:4];
        a        = model_regs[dst];
        b        = model_regs[src];
        model_pc = model_pc + ROM_ADDR_W'(1);
        found    = 1'b1;
        case (opcode_t'(word[15:12]))
            LDI: val = {8'h00, word[7:0]};
            MOV: val = b;
            ADD: val = a + b;
            SUB: val = a - b;
            AND: val = a & b;
            XOR: val = a ^ b;
            IN: begin
                if (src == REG_IDX_W'(NUM_EXT_INPUTS)) begin
                    val = model_replies;              // Slot 15 is the mailbox reply.
                end else begin
                    val = ext[src*WORD_W +: WORD_W];
                end
            end
            JMP: begin
                model_pc = word[7:0];
                found    = 1'b0;
            end
            JNZ: begin
                if (a != '0) begin
                    model_pc = word[7:0];
                end
                found = 1'b0;
            end
            default: found = 1'b0;
        endcase
    end
    if (found) begin
        idx             = dst;
        model_regs[dst] = val;
        if (dst == REG_IDX_W'(MAILBOX_REG)) begin
            model_replies = model_replies + WORD_W'(1);
            model_led     = val[LED_W-1:0];
        end
    end
endtask

// True when the program loops from here on without another register write.
function automatic bit model_stalled();
    logic [ROM_ADDR_W-1:0] pc;
    logic [WORD_W-1:0]     word;
    pc = model_pc;
    for (int n = 0; n < 32; n++) begin
        word = model_rom[pc];
        case (opcode_t'(word[15:12]))
            LDI, MOV, ADD, SUB, AND, XOR, IN: return 1'b0;
            JMP: pc = word[7:0];
            JNZ: begin
                if (model_regs[word[11:8]] != '0) begin
                    pc = word[7:0];
                end else begin
                    pc = pc + ROM_ADDR_W'(1);
                end
            end
            default: pc = pc + ROM_ADDR_W'(1);
        endcase
    end
    return 1'b1;
endfunction

`endif

//--- verification/tb_supervised_synapse316.sv
`timescale 1ns/1ps

module tb_supervised_synapse316 import synapse_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS     = 8;
    localparam int ROW_CYCLES   = WATCHDOG_CYCLES + 200;        // Worst case for one stall row.
    localparam logic [NUM_ROWS-1:0] STALL_ROWS = 8'b0100_1000;   // Rows 3 and 6 stall.

    logic                             sysclk;
    logic                             arst_n;
    logic [NUM_EXT_INPUTS*WORD_W-1:0] data_in_flat;
    logic [NUM_REGS*WORD_W-1:0]       r_flat;
    logic [NUM_REGS-1:0]              r_load;
    logic [LED_W-1:0]                 led;

    typedef struct packed {
        logic                             stall;
        logic [NUM_EXT_INPUTS*WORD_W-1:0] words;
    } row_t;

    row_t rows [NUM_ROWS];
    int   errors;
    int   writes_seen;

    `include "isa_model.svh"

    supervised_synapse316 uut (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .data_in_flat (data_in_flat),
        .r_flat       (r_flat),
        .r_load       (r_load),
        .led          (led)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    initial begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
        $display("Timeout at %0t, the DUT stopped making progress, %0d errors.", $time, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_led(input logic [LED_W-1:0] got, input logic [LED_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t led got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_load(input logic [NUM_REGS-1:0] got, input logic [NUM_REGS-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t r_load got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_regs_against(input logic [WORD_W-1:0] exp [NUM_REGS]);
        for (int i = 0; i < NUM_REGS; i++) begin
            check_word($sformatf("r_flat[r%0d]", i), r_flat[i*WORD_W +: WORD_W], exp[i]);
        end
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r].stall = STALL_ROWS[r];
            for (int s = 0; s < NUM_EXT_INPUTS; s++) begin
                rows[r].words[s*WORD_W +: WORD_W] = WORD_W'($urandom);
            end
            if (rows[r].stall) begin
                rows[r].words[WORD_W-1:0] = 16'hFFFF;      // Input 0 + 1 wraps to zero, JNZ falls through.
            end else if (rows[r].words[WORD_W-1:0] == 16'hFFFF) begin
                rows[r].words[WORD_W-1:0] = 16'h0000;
            end
        end
    endtask

    // One DUT register write against the model's next write.
    task automatic compare_write();
        logic [REG_IDX_W-1:0] idx;
        logic [WORD_W-1:0]    val;
        bit                   found;
        check_led(led, model_led);                        // Set by the previous register 15 write.
        model_next_write(data_in_flat, found, idx, val);
        if (!found) begin
            errors++;
            $display("The DUT wrote a register at %0t but the program has no write left.", $time);
        end else begin
            check_load(r_load, NUM_REGS'(1) << idx);
            check_regs_against(model_regs);
        end
        writes_seen++;
    endtask

    task automatic await_restart();
        logic [WORD_W-1:0] zeros [NUM_REGS];
        int                cycles;
        zeros  = '{default: '0};
        cycles = 0;
        while (r_flat != '0 && cycles < ROW_CYCLES) begin
            @(negedge sysclk);
            cycles++;
            if (r_load != '0) begin
                errors++;
                $display("A register was written at %0t while the program was stalled.", $time);
            end
        end
        if (cycles < WATCHDOG_CYCLES - 64) begin
            errors++;
            $display("The watchdog restarted the core after only %0d silent cycles.", cycles);
        end
        check_regs_against(zeros);                        // Stays nonzero if no restart came.
        check_led(led, model_led);
        model_restart();
    endtask

    task automatic run_row(input int r);
        logic [WORD_W-1:0] zeros [NUM_REGS];
        logic [WORD_W-1:0] start_replies;
        bit                done;
        zeros         = '{default: '0};
        start_replies = model_replies;
        done          = 1'b0;
        while (!done) begin
            @(negedge sysclk);
            if (r_load != '0) begin
                compare_write();
                if (rows[r].stall && model_stalled()) begin
                    await_restart();
                    done = 1'b1;
                end else if (model_replies != start_replies) begin
                    done = 1'b1;
                end
            end else if (writes_seen == 0) begin
                check_regs_against(zeros);                // Nothing written since reset.
                check_led(led, '0);
            end
        end
        @(posedge sysclk);
        #1;
        if (r + 1 < NUM_ROWS) begin
            data_in_flat = rows[r + 1].words;
        end
    endtask

    initial begin
        errors      = 0;
        writes_seen = 0;
        arst_n      = 1'b0;
        void'($urandom(32'h9defe26a));
        build_table();
        data_in_flat = rows[0].words;
        model_load();
        repeat (RESET_CYCLES) @(posedge sysclk);
        #1;
        arst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        @(negedge sysclk);
        check_led(led, model_led);                        // Latched from the last mailbox write.
        $display("%0d register writes compared, %0d errors.", writes_seen, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
